//--- common/viaPkg.sv
// Shared register map, widths and flag positions of the interface adapter
// Imported by every RTL block that decodes addresses or handles flags
`default_nettype none

package viaPkg;

	localparam int viaDataW = 8;	// Bus and port width
	localparam int viaAddrW = 4;	// Register select width
	localparam int viaFlagW = 7;	// Interrupt flag and enable width

	typedef logic [viaAddrW-1:0] viaAddrT;

	// Register select values as seen on the host bus
	localparam viaAddrT addrOrb     = 4'd0;
	localparam viaAddrT addrOra     = 4'd1;
	localparam viaAddrT addrDdrb    = 4'd2;
	localparam viaAddrT addrDdra    = 4'd3;
	localparam viaAddrT addrT1CntLo = 4'd4;
	localparam viaAddrT addrT1CntHi = 4'd5;	// Write loads counter and arms
	localparam viaAddrT addrT1LatLo = 4'd6;
	localparam viaAddrT addrT1LatHi = 4'd7;
	localparam viaAddrT addrAcr     = 4'd11;
	localparam viaAddrT addrPcr     = 4'd12;
	localparam viaAddrT addrIfr     = 4'd13;
	localparam viaAddrT addrIer     = 4'd14;
	localparam viaAddrT addrOraNh   = 4'd15;	// Port A alias

	// Bit positions inside the flag and enable registers
	localparam int flagCtl2 = 0;	// ctlA2 edge
	localparam int flagCtl1 = 1;	// ctlA1 edge
	localparam int flagT1   = 6;	// Timer 1 timeout

	localparam int syncDepth = 2;	// Stages on each control line

endpackage

`default_nettype wire

//--- flist.f
common/viaPkg.sv
source/viaBusDecode.sv
source/viaPortBlock.sv
timer/viaTimer1.sv
irq/viaIrqCtrl.sv
source/viaReadMux.sv
source/viaTop.sv
verif/viaClockGen.sv
verif/viaTb.sv

//--- irq/viaIrqCtrl.sv
// Interrupt side of the adapter: control registers, ctlA1/ctlA2 edges,
// interrupt flags and enables, and the registered active-low irqN
`default_nettype none

module viaIrqCtrl import viaPkg::*; (
	input  wire                 CA1,
	input  wire                 IFR,
	input  wire                 accStb,
	input  wire                 accWr,
	input  wire viaAddrT        accAddr,
	input  wire [viaDataW-1:0]  accData,
	input  wire                 ctlA1,
	input  wire                 ctlA2,
	input  wire                 t1Event,
	output logic [viaDataW-1:0] acr,
	output logic [viaDataW-1:0] pcr,
	output logic                freeRun,
	output logic [viaFlagW-1:0] intFlag,
	output logic [viaFlagW-1:0] intEnable,
	output logic                irqN
);

	logic [syncDepth-1:0] syncA1;
	logic [syncDepth-1:0] syncA2;
	logic                 lastA1;
	logic                 lastA2;
	logic                 hitA1;
	logic                 hitA2;
	logic                 edgeA1;	// Registered edge pulses
	logic                 edgeA2;
	logic [viaFlagW-1:0]  setMask;
	logic [viaFlagW-1:0]  clrMask;

	// pcr bit 0 and bit 2 pick rising (1) or falling (0) edges
	assign hitA1 = pcr[0] ? (syncA1[syncDepth-1] & ~lastA1) : (~syncA1[syncDepth-1] & lastA1);
	assign hitA2 = pcr[2] ? (syncA2[syncDepth-1] & ~lastA2) : (~syncA2[syncDepth-1] & lastA2);

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			syncA1 <= '0;
			syncA2 <= '0;
			lastA1 <= 1'b0;
			lastA2 <= 1'b0;
			edgeA1 <= 1'b0;
			edgeA2 <= 1'b0;
		end else begin
			syncA1 <= {syncA1[syncDepth-2:0], ctlA1};
			syncA2 <= {syncA2[syncDepth-2:0], ctlA2};
			lastA1 <= syncA1[syncDepth-1];
			lastA2 <= syncA2[syncDepth-1];
			edgeA1 <= hitA1;
			edgeA2 <= hitA2;
		end
	end

	always_comb begin
		setMask           = '0;
		setMask[flagCtl1] = edgeA1;
		setMask[flagCtl2] = edgeA2;
		setMask[flagT1]   = t1Event;
		clrMask           = '0;
		if (accStb && accWr && (accAddr == addrIfr)) begin
			clrMask = accData[viaFlagW-1:0];	// Write 1 to clear
		end
		if (accStb && ((accAddr == addrOra) || (accAddr == addrOraNh))) begin
			clrMask[flagCtl1] = 1'b1;
			clrMask[flagCtl2] = 1'b1;
		end
		if (accStb && ((!accWr && (accAddr == addrT1CntLo))
				|| (accWr && (accAddr == addrT1CntHi)))) begin
			clrMask[flagT1] = 1'b1;
		end
	end

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			acr       <= '0;
			pcr       <= '0;
			intFlag   <= '0;
			intEnable <= '0;
			irqN      <= 1'b1;
		end else begin
			if (accStb && accWr && (accAddr == addrAcr)) begin
				acr <= accData;
			end
			if (accStb && accWr && (accAddr == addrPcr)) begin
				pcr <= accData;
			end
			if (accStb && accWr && (accAddr == addrIer)) begin
				intEnable <= accData[viaDataW-1] ? (intEnable | accData[viaFlagW-1:0])
					: (intEnable & ~accData[viaFlagW-1:0]);	// Bit 7 picks set or clear
			end
			intFlag <= (intFlag & ~clrMask) | setMask;	// New event beats a clear
			irqN    <= ~|(intFlag & intEnable);
		end
	end

	assign freeRun = acr[6];

endmodule

`default_nettype wire

//--- source/viaBusDecode.sv
// Host bus front end of the adapter
// Turns each four-phase req/ack transfer into a single access strobe
`default_nettype none

module viaBusDecode import viaPkg::*; (
	input  wire                 CA1,
	input  wire                 IFR,
	input  wire                 req,
	input  wire                 wr,
	input  wire viaAddrT        addr,
	input  wire [viaDataW-1:0]  wData,
	output logic                ack,
	output logic                accStb,
	output logic                accWr,
	output viaAddrT             accAddr,
	output logic [viaDataW-1:0] accData
);

	typedef enum logic [1:0] {
		stIdle,
		stStrobe,
		stAck
	} stateT;

	stateT state;
	logic  newReq;

	assign newReq = (state == stIdle) && req;	// Ack is low whenever idle

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: begin
					if (req) begin
						state <= stStrobe;
					end
				end
				stStrobe: begin
					state <= stAck;	// Access executes on this edge
				end
				stAck: begin
					if (!req) begin
						state <= stIdle;	// Host released the bus
					end
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

	// Request fields are held for the strobe cycle
	always_ff @(posedge CA1) begin
		if (newReq) begin
			accWr   <= wr;
			accAddr <= addr;
			accData <= wData;
		end
	end

	assign accStb = (state == stStrobe);
	assign ack    = (state == stAck);

endmodule

`default_nettype wire

//--- source/viaPortBlock.sv
// One 8-bit I/O port with output and direction registers
// Instantiated once for port A and once for port B
`default_nettype none

module viaPortBlock import viaPkg::*; #(
	parameter viaAddrT dataAddr = addrOra,
	parameter viaAddrT dirAddr  = addrDdra
) (
	input  wire                 CA1,
	input  wire                 IFR,
	input  wire                 accStb,
	input  wire                 accWr,
	input  wire viaAddrT        accAddr,
	input  wire [viaDataW-1:0]  accData,
	input  wire [viaDataW-1:0]  portIn,
	output logic [viaDataW-1:0] portOut,
	output logic [viaDataW-1:0] portOe,
	output logic [viaDataW-1:0] portRead,
	output logic [viaDataW-1:0] ddr
);

	localparam bit nhAlias = (dataAddr == addrOra);	// Port A also decodes address 15

	logic [viaDataW-1:0] outReg;
	logic                dataHit;
	logic                dirHit;

	assign dataHit = accStb && accWr
		&& ((accAddr == dataAddr) || (nhAlias && (accAddr == addrOraNh)));
	assign dirHit  = accStb && accWr && (accAddr == dirAddr);

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			outReg <= '0;
			ddr    <= '0;	// All pins start as inputs
		end else begin
			if (dataHit) begin
				outReg <= accData;
			end
			if (dirHit) begin
				ddr <= accData;
			end
		end
	end

	assign portOut = outReg;
	assign portOe  = ddr;

	// Output bits read back the register, input bits read the pin
	assign portRead = (outReg & ddr) | (portIn & ~ddr);

endmodule

`default_nettype wire

//--- source/viaReadMux.sv
// Read data path of the adapter
// Picks the addressed register on a read strobe and holds it on rData
`default_nettype none

module viaReadMux import viaPkg::*; (
	input  wire                   CA1,
	input  wire                   IFR,
	input  wire                   accStb,
	input  wire                   accWr,
	input  wire viaAddrT          accAddr,
	input  wire [viaDataW-1:0]    portReadA,
	input  wire [viaDataW-1:0]    portReadB,
	input  wire [viaDataW-1:0]    ddrA,
	input  wire [viaDataW-1:0]    ddrB,
	input  wire [2*viaDataW-1:0]  cntValue,
	input  wire [viaDataW-1:0]    latLo,
	input  wire [viaDataW-1:0]    acr,
	input  wire [viaDataW-1:0]    pcr,
	input  wire [viaFlagW-1:0]    intFlag,
	input  wire [viaFlagW-1:0]    intEnable,
	input  wire                   irqN,
	output logic [viaDataW-1:0]   rData
);

	logic [viaDataW-1:0] readSel;

	always_comb begin
		case (accAddr)
			addrOrb:            readSel = portReadB;
			addrOra, addrOraNh: readSel = portReadA;
			addrDdrb:           readSel = ddrB;
			addrDdra:           readSel = ddrA;
			addrT1CntLo:        readSel = cntValue[viaDataW-1:0];
			addrT1CntHi:        readSel = cntValue[2*viaDataW-1:viaDataW];
			addrT1LatLo:        readSel = latLo;
			addrAcr:            readSel = acr;
			addrPcr:            readSel = pcr;
			addrIfr:            readSel = {~irqN, intFlag};	// Bit 7 shows a pending irq
			addrIer:            readSel = {1'b1, intEnable};
			default:            readSel = '0;
		endcase
	end

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			rData <= '0;
		end else if (accStb && !accWr) begin
			rData <= readSel;	// Held until the next read
		end
	end

endmodule

`default_nettype wire

//--- source/viaTop.sv
// Top level of the cut-down 6522 interface adapter
// Ties the bus front end to the ports, timer, interrupt logic and read path
`default_nettype none

module viaTop import viaPkg::*; (
	input  wire                 CA1,
	input  wire                 IFR,
	input  wire                 req,
	input  wire                 wr,
	input  wire viaAddrT        addr,
	input  wire [viaDataW-1:0]  wData,
	input  wire [viaDataW-1:0]  portAIn,
	input  wire [viaDataW-1:0]  portBIn,
	input  wire                 ctlA1,
	input  wire                 ctlA2,
	output logic                ack,
	output logic [viaDataW-1:0] rData,
	output logic [viaDataW-1:0] portAOut,
	output logic [viaDataW-1:0] portAOe,
	output logic [viaDataW-1:0] portBOut,
	output logic [viaDataW-1:0] portBOe,
	output logic                irqN
);

	logic                  accStb;
	logic                  accWr;
	viaAddrT               accAddr;
	logic [viaDataW-1:0]   accData;
	logic [viaDataW-1:0]   portReadA;
	logic [viaDataW-1:0]   portReadB;
	logic [viaDataW-1:0]   ddrA;
	logic [viaDataW-1:0]   ddrB;
	logic [2*viaDataW-1:0] cntValue;
	logic [viaDataW-1:0]   latLo;
	logic [viaDataW-1:0]   acr;
	logic [viaDataW-1:0]   pcr;
	logic [viaFlagW-1:0]   intFlag;
	logic [viaFlagW-1:0]   intEnable;
	logic                  t1Event;
	logic                  freeRun;

	viaBusDecode decode (
		.CA1, .IFR, .req, .wr, .addr, .wData,
		.ack, .accStb, .accWr, .accAddr, .accData
	);

	viaPortBlock #(.dataAddr(addrOra), .dirAddr(addrDdra)) portA (
		.CA1, .IFR, .accStb, .accWr, .accAddr, .accData,
		.portIn(portAIn), .portOut(portAOut), .portOe(portAOe),
		.portRead(portReadA), .ddr(ddrA)
	);

	viaPortBlock #(.dataAddr(addrOrb), .dirAddr(addrDdrb)) portB (
		.CA1, .IFR, .accStb, .accWr, .accAddr, .accData,
		.portIn(portBIn), .portOut(portBOut), .portOe(portBOe),
		.portRead(portReadB), .ddr(ddrB)
	);

	viaTimer1 timer1 (
		.CA1, .IFR, .accStb, .accWr, .accAddr, .accData, .freeRun,
		.cntValue, .latLo, .t1Event
	);

	viaIrqCtrl irqCtrl (
		.CA1, .IFR, .accStb, .accWr, .accAddr, .accData, .ctlA1, .ctlA2, .t1Event,
		.acr, .pcr, .freeRun, .intFlag, .intEnable, .irqN
	);

	viaReadMux readMux (
		.CA1, .IFR, .accStb, .accWr, .accAddr, .portReadA, .portReadB, .ddrA, .ddrB,
		.cntValue, .latLo, .acr, .pcr, .intFlag, .intEnable, .irqN, .rData
	);

endmodule

`default_nettype wire

//--- timer/viaTimer1.sv
// Timer 1 of the adapter with its 16-bit latch and down-counter
// Runs one-shot or free-running and pulses t1Event on each timeout
`default_nettype none

module viaTimer1 import viaPkg::*; (
	input  wire                   CA1,
	input  wire                   IFR,
	input  wire                   accStb,
	input  wire                   accWr,
	input  wire viaAddrT          accAddr,
	input  wire [viaDataW-1:0]    accData,
	input  wire                   freeRun,
	output logic [2*viaDataW-1:0] cntValue,
	output logic [viaDataW-1:0]   latLo,
	output logic                  t1Event
);

	logic [viaDataW-1:0] latHi;
	logic                armed;
	logic                wrLatLo;
	logic                wrLatHi;
	logic                wrCntHi;
	logic                cntZero;

	assign wrLatLo = accStb && accWr
		&& ((accAddr == addrT1CntLo) || (accAddr == addrT1LatLo));
	assign wrLatHi = accStb && accWr && (accAddr == addrT1LatHi);
	assign wrCntHi = accStb && accWr && (accAddr == addrT1CntHi);
	assign cntZero = (cntValue == '0);

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			latLo <= '0;
			latHi <= '0;
		end else begin
			if (wrLatLo) begin
				latLo <= accData;
			end
			if (wrLatHi || wrCntHi) begin
				latHi <= accData;	// Counter load also updates the latch
			end
		end
	end

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			cntValue <= '0;
			armed    <= 1'b0;
			t1Event  <= 1'b0;
		end else begin
			t1Event <= 1'b0;
			if (wrCntHi) begin
				cntValue <= {accData, latLo};	// Load and start a new period
				armed    <= 1'b1;
			end else if (cntZero) begin
				cntValue <= {latHi, latLo};	// Reload from latch
				if (armed) begin
					t1Event <= 1'b1;
					armed   <= freeRun;	// One-shot stops after first timeout
				end
			end else begin
				cntValue <= cntValue - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/viaClockGen.sv
// Clock and reset source for the adapter testbench
// CA1 runs at a 40 ns period and IFR is held over the first two rising edges
`default_nettype none

module viaClockGen (
	output logic CA1,
	output logic IFR
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int halfPeriod = 20;

	initial begin
		CA1 = 1'b0;
		forever #halfPeriod CA1 = ~CA1;
	end

	initial begin
		IFR = 1'b1;
		repeat (2) @(posedge CA1);
		#2 IFR = 1'b0;	// Released just after the second edge
	end

endmodule

`default_nettype wire

//--- verif/viaTb.sv
// Testbench of the cut-down 6522 interface adapter
// Runs reset, port, control line, timer and handshake tests against a register model
`default_nettype none

module viaTb import viaPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPeriod      = 40;
	localparam int ackLimit       = 16;	// Cycles allowed for each ack edge
	localparam int timerCount     = 64;
	localparam int accessCount    = 200;
	localparam int watchdogCycles = accessCount * 8 + 12 * (timerCount + 8) + 800;

	logic                CA1;
	logic                IFR;
	logic                req;
	logic                wr;
	viaAddrT             addr;
	logic [viaDataW-1:0] wData;
	logic [viaDataW-1:0] portAIn;
	logic [viaDataW-1:0] portBIn;
	logic                ctlA1;
	logic                ctlA2;
	logic                ack;
	logic [viaDataW-1:0] rData;
	logic [viaDataW-1:0] portAOut;
	logic [viaDataW-1:0] portAOe;
	logic [viaDataW-1:0] portBOut;
	logic [viaDataW-1:0] portBOe;
	logic                irqN;

	logic [viaDataW-1:0] refReg [16];	// Register model indexed by bus address
	logic [31:0]         lcgState = 32'hb2a2;
	logic [viaDataW-1:0] expRead;
	logic [viaDataW-1:0] lastRead;
	string               checkName;
	bit                  checkPending = 1'b0;
	bit                  ackPrev = 1'b0;
	bit                  reqPrev = 1'b0;
	int                  mismatchCount = 0;
	int                  failCount = 0;

	viaClockGen clockGen (.CA1, .IFR);

	viaTop i_viaTop (
		.CA1, .IFR, .req, .wr, .addr, .wData, .portAIn, .portBIn, .ctlA1, .ctlA2,
		.ack, .rData, .portAOut, .portAOe, .portBOut, .portBOe, .irqN
	);

	function automatic logic [viaDataW-1:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[23:16];
	endfunction

	function automatic logic [viaDataW-1:0] pinView(input logic [viaDataW-1:0] o, d, p);
		logic [viaDataW-1:0] v;
		for (int i = 0; i < viaDataW; i++) begin
			v[i] = d[i] ? o[i] : p[i];	// Outputs read the register
		end
		return v;
	endfunction

	// Expected read value from the model and the pins now driven
	function automatic logic [viaDataW-1:0] expectRead(input viaAddrT a);
		logic [viaFlagW-1:0] flags;
		flags = refReg[addrIfr][viaFlagW-1:0];
		case (a)
			addrOrb:            return pinView(refReg[addrOrb], refReg[addrDdrb], portBIn);
			addrOra, addrOraNh: return pinView(refReg[addrOra], refReg[addrDdra], portAIn);
			addrDdrb, addrDdra, addrT1LatLo, addrAcr, addrPcr: return refReg[a];
			addrIfr:            return {|(flags & refReg[addrIer][viaFlagW-1:0]), flags};
			addrIer:            return {1'b1, refReg[addrIer][viaFlagW-1:0]};
			default:            return '0;
		endcase
	endfunction

	task automatic reportMismatch(input string name, input logic [15:0] expVal, actVal);
		mismatchCount++;
		$display("MISMATCH %s expected %h actual %h at %0t", name, expVal, actVal, $time);
	endtask

	task automatic reportFailure(input string what);
		failCount++;
		$display("ERROR %s at %0t", what, $time);
	endtask

	task automatic updateModel(input bit isWr, input viaAddrT a, input logic [viaDataW-1:0] d);
		if (isWr) begin
			case (a)
				addrOraNh:   refReg[addrOra] = d;
				addrT1CntLo: refReg[addrT1LatLo] = d;
				addrT1CntHi: refReg[addrIfr][flagT1] = 1'b0;
				addrIfr:     refReg[addrIfr] = refReg[addrIfr] & ~{1'b0, d[viaFlagW-1:0]};
				addrIer: begin
					for (int i = 0; i < viaFlagW; i++) begin
						if (d[i]) refReg[addrIer][i] = d[7];	// Bit 7 says set or clear
					end
				end
				default:     refReg[a] = d;
			endcase
		end else if (a == addrT1CntLo) begin
			refReg[addrIfr][flagT1] = 1'b0;
		end
		if ((a == addrOra) || (a == addrOraNh)) begin
			refReg[addrIfr][flagCtl1] = 1'b0;	// Any port A access
			refReg[addrIfr][flagCtl2] = 1'b0;
		end
	endtask

	// One four-phase transfer, req optionally held for extra cycles after ack
	task automatic busAccess(input bit isWr, input viaAddrT a, input logic [viaDataW-1:0] d,
			input int holdCycles);
		int n;
		@(posedge CA1);
		#2;
		req   = 1'b1;
		wr    = isWr;
		addr  = a;
		wData = d;
		n = 0;
		do begin
			@(posedge CA1);
			n++;
		end while (!ack && (n < ackLimit));
		if (!ack) reportFailure($sformatf("no ack for access to address %0d", a));
		lastRead = rData;
		repeat (holdCycles) begin
			@(posedge CA1);
			if (!ack) reportFailure("ack dropped while req was held");
			if (rData !== lastRead) reportFailure("rData changed while req was held");
		end
		#2;
		req = 1'b0;
		n = 0;
		do begin
			@(posedge CA1);
			n++;
		end while (ack && (n < ackLimit));
		if (ack) reportFailure("ack stayed high after req dropped");
		updateModel(isWr, a, d);
	endtask

	task automatic writeReg(input viaAddrT a, input logic [viaDataW-1:0] d);
		busAccess(1'b1, a, d, 0);
	endtask

	task automatic checkRead(input string name, input viaAddrT a);
		expRead      = expectRead(a);
		checkName    = name;
		checkPending = 1'b1;
		busAccess(1'b0, a, '0, 0);
	endtask

	// Synchronizer plus edge register need up to 4 cycles
	task automatic setCtl(input logic a1, input logic a2);
		@(posedge CA1);
		#2;
		ctlA1 = a1;
		ctlA2 = a2;
		repeat (6) @(posedge CA1);
	endtask

	task automatic checkIrqPin(input string name);
		logic expIrqN;
		repeat (2) @(posedge CA1);
		expIrqN = ~|(refReg[addrIfr] & refReg[addrIer]);
		if (irqN !== expIrqN) reportMismatch(name, expIrqN, irqN);
	endtask

	task automatic waitTimeout(input string name, input int limit);
		int n;
		n = 0;
		while (irqN && (n < limit)) begin
			@(posedge CA1);
			n++;
		end
		if (irqN) begin
			reportFailure($sformatf("%s did not set the timer flag in %0d cycles",
				name, limit));
		end
		refReg[addrIfr][flagT1] = 1'b1;
	endtask

	// Handshake rules and read compare on each rising edge
	always @(posedge CA1) begin
		if (!IFR) begin
			if (ack && !ackPrev && !reqPrev) reportFailure("ack rose without a request");
			if (!ack && ackPrev && reqPrev) reportFailure("ack fell while req was held");
			if (ack && !ackPrev && checkPending) begin
				if (rData !== expRead) reportMismatch(checkName, expRead, rData);
				checkPending = 1'b0;
			end
		end
		ackPrev = ack;
		reqPrev = req;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog expired after %0d cycles, the run is stuck", watchdogCycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : mainSeq
		logic [viaDataW-1:0] cnt1;
		req     = 1'b0;
		wr      = 1'b0;
		addr    = '0;
		wData   = '0;
		portAIn = '0;
		portBIn = '0;
		ctlA1   = 1'b0;
		ctlA2   = 1'b0;
		foreach (refReg[i]) refReg[i] = '0;
		@(negedge IFR);
		@(posedge CA1);
		if (ack !== 1'b0) reportFailure("ack is not low after reset");
		if (irqN !== 1'b1) reportFailure("irqN is not high after reset");
		if ((portAOe !== '0) || (portBOe !== '0)) begin
			reportFailure("port enables not zero after reset");
		end
		checkRead("reset ddrb", addrDdrb);
		checkRead("reset ddra", addrDdra);
		checkRead("reset acr", addrAcr);
		checkRead("reset pcr", addrPcr);
		checkRead("reset ier", addrIer);
		checkRead("reset ifr", addrIfr);

		for (int i = 0; i < 8; i++) begin
			writeReg(addrDdra, nextRand());
			writeReg((i % 2) ? addrOraNh : addrOra, nextRand());
			writeReg(addrDdrb, nextRand());
			writeReg(addrOrb, nextRand());
			@(posedge CA1);
			#2;
			portAIn = nextRand();
			portBIn = nextRand();
			if (portAOut !== refReg[addrOra]) reportMismatch("port A out", refReg[addrOra], portAOut);
			if (portAOe !== refReg[addrDdra]) reportMismatch("port A oe", refReg[addrDdra], portAOe);
			if (portBOut !== refReg[addrOrb]) reportMismatch("port B out", refReg[addrOrb], portBOut);
			if (portBOe !== refReg[addrDdrb]) reportMismatch("port B oe", refReg[addrDdrb], portBOe);
			checkRead("port B read", addrOrb);
			checkRead("port A read", addrOra);
			checkRead("port A alias read", addrOraNh);
		end

		for (int pol = 0; pol < 2; pol++) begin
			writeReg(addrPcr, (pol == 1) ? 8'h05 : 8'h00);
			setCtl(pol == 0, pol == 0);	// Park before the active edge
			writeReg(addrIfr, 8'h7f);
			checkRead("ctl flags idle", addrIfr);
			setCtl(pol == 1, pol == 0);
			refReg[addrIfr][flagCtl1] = 1'b1;
			checkRead("ctlA1 active edge", addrIfr);
			setCtl(pol == 1, pol == 1);
			refReg[addrIfr][flagCtl2] = 1'b1;
			checkRead("ctlA2 active edge", addrIfr);
			writeReg(addrIer, 8'h83);
			checkRead("enable set", addrIer);
			checkIrqPin("irqN with enabled flags");
			writeReg(addrIer, 8'h02);
			checkIrqPin("irqN with one enable");
			writeReg(addrIer, 8'h01);
			checkRead("enable clear", addrIer);
			checkIrqPin("irqN with no enables");
			writeReg(addrIfr, 8'h02);
			checkRead("flag write clear", addrIfr);
			checkRead("port A read clears", addrOra);
			checkRead("ctl flags after port A", addrIfr);
			setCtl(pol == 0, pol == 0);	// Opposite edges with both flags clear
			checkRead("ctl opposite edge", addrIfr);
		end

		writeReg(addrIer, 8'hc0);	// Timer flag alone drives irqN
		writeReg(addrAcr, 8'h00);
		writeReg(addrT1CntLo, timerCount);
		checkRead("latch low from counter write", addrT1LatLo);
		writeReg(addrT1CntHi, 8'h00);
		waitTimeout("one-shot load", timerCount + 8);
		checkRead("timer flag set", addrIfr);
		busAccess(1'b0, addrT1CntLo, '0, 0);
		checkRead("timer flag cleared", addrIfr);
		repeat (3 * (timerCount + 2)) @(posedge CA1);
		checkRead("one-shot stays quiet", addrIfr);

		writeReg(addrAcr, 8'h40);
		writeReg(addrT1CntHi, 8'h00);
		busAccess(1'b0, addrT1CntLo, '0, 0);
		cnt1 = lastRead;
		busAccess(1'b0, addrT1CntLo, '0, 0);
		if (lastRead >= cnt1) reportFailure("counter did not decrease between two reads");
		waitTimeout("free-run load", timerCount + 8);
		busAccess(1'b0, addrT1CntLo, '0, 0);
		waitTimeout("free-run reload", timerCount + 8);
		writeReg(addrAcr, 8'h00);	// Disarms at the next timeout
		busAccess(1'b0, addrT1CntLo, '0, 0);
		waitTimeout("last free-run period", timerCount + 8);
		busAccess(1'b0, addrT1CntLo, '0, 0);

		writeReg(addrT1CntHi, 8'h00);
		waitTimeout("load before long read", timerCount + 8);
		busAccess(1'b0, addrT1CntLo, '0, 20);
		checkRead("flag after long read", addrIfr);
		checkIrqPin("irqN after long read");

		$display("Checks done: %0d mismatches, %0d other errors", mismatchCount, failCount);
		if ((mismatchCount + failCount) == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
